//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module nfcCmdTb -f src.f -o nfcCmdSim \
    && ./obj_dir/nfcCmdSim \
    || { echo "nfcCmd simulation failed"; exit 1; }

//--- source/nfcCaShifter.sv
`timescale 1ns/1ps

module nfcCaShifter (
    input  logic                   iSystemClock,
    input  logic                   rst,
    input  logic                   load,
    input  logic                   advance,
    input  nfcCmdPkg::cmdRequest_t request,
    output nfcCmdPkg::cmdRequest_t held,
    output nfcCmdPkg::caByte_t     currentByte,
    output logic                   lastByte
);

    import nfcCmdPkg::*;

    byteCount_t byteIndex;
    byteCount_t clippedCount;

    // counts above the last byte index act as the last byte index
    assign clippedCount = (request.numOfData > MaxByteIndex) ? MaxByteIndex
                                                             : request.numOfData;

    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            byteIndex <= '0;
        end else if (load) begin
            byteIndex <= '0;
        end else if (advance) begin
            byteIndex <= byteIndex + 1'b1;
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (load) begin
            held.targetWay <= request.targetWay;
            held.numOfData <= clippedCount;
            held.caSelect  <= request.caSelect;
            held.caData    <= request.caData;
        end else if (advance) begin
            held.caData <= held.caData << $bits(caByte_t); // next byte to the top
        end
    end

    // most significant byte goes out first
    assign currentByte = held.caData[$bits(caData_t)-1 -: $bits(caByte_t)];
    assign lastByte    = (byteIndex == held.numOfData);

endmodule

//--- source/nfcCmdPkg.sv
package nfcCmdPkg;

    localparam int NumberOfWays = 4;

    // widths with a meaning
    typedef logic [NumberOfWays-1:0]   wayMask_t;
    typedef logic [2*NumberOfWays-1:0] chipEnable_t; // active low, two pad halves
    typedef logic [3:0]                byteCount_t;  // byte count minus one
    typedef logic [39:0]               caData_t;
    typedef logic [7:0]                caByte_t;
    typedef logic [31:0]               dqWord_t;
    typedef logic [3:0]                laneCtl_t;
    typedef logic [3:0]                timerCount_t;

    // phase timing
    localparam timerCount_t TimerLast     = 4'd9; // 10 cycles per phase
    localparam timerCount_t StrobeLowLast = 4'd4; // write enable low for 5 cycles
    localparam byteCount_t  MaxByteIndex  = 4'd4; // five bytes at most

    // pad lane patterns
    localparam laneCtl_t LaneActive = 4'b0011;
    localparam laneCtl_t LaneIdle   = 4'b0000;
    localparam laneCtl_t WeActive   = 4'b0000;
    localparam laneCtl_t WeIdle     = 4'b0011;

    typedef struct packed {
        wayMask_t   targetWay;
        byteCount_t numOfData;
        logic       caSelect;  // high for command
        caData_t    caData;
    } cmdRequest_t;

    typedef struct packed {
        chipEnable_t chipEnable;
        laneCtl_t    writeEnable;
        laneCtl_t    addressLatchEnable;
        laneCtl_t    commandLatchEnable;
        dqWord_t     dq;
    } padBus_t;

    // Latch also opens the setup window at the pads, which lag by one cycle
    typedef enum logic [1:0] {
        Ready,
        Latch,
        Setup,
        Output
    } cmdState_t;

endpackage

//--- source/nfcCmdSequencer.sv
`timescale 1ns/1ps

module nfcCmdSequencer (
    input  logic                 iSystemClock,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 phaseDone,
    input  logic                 lastByte,
    output nfcCmdPkg::cmdState_t state,
    output logic                 timerClear,
    output logic                 load,
    output logic                 advance,
    output logic                 ready,
    output logic                 lastStep
);

    import nfcCmdPkg::*;

    cmdState_t nextState;
    logic      startTaken;
    logic      finalCycle;

    // ready is only ever high in Ready
    assign startTaken = ready && start;

    // timer restarts so that count 0 lines up with Latch
    assign timerClear = startTaken;
    assign load       = startTaken;

    assign finalCycle = (state == Output) && phaseDone && lastByte;
    assign advance    = (state == Output) && phaseDone && !lastByte;

    always_comb begin
        nextState = state;
        case (state)
            Ready: begin
                if (startTaken) begin
                    nextState = Latch;
                end
            end
            Latch: begin
                nextState = Setup;
            end
            Setup: begin
                if (phaseDone) begin
                    nextState = Output;
                end
            end
            Output: begin
                if (finalCycle) begin
                    nextState = Ready;
                end
            end
            default: begin
                nextState = Ready;
            end
        endcase
    end

    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            state    <= Ready;
            ready    <= 1'b0;
            lastStep <= 1'b0;
        end else begin
            state <= nextState;
            // one cycle late on return, the pads still show the last byte
            ready    <= (state == Ready) && !startTaken;
            lastStep <= finalCycle;
        end
    end

endmodule

//--- source/nfcCmdTop.sv
`timescale 1ns/1ps

module nfcCmdTop (
    input  logic                   iSystemClock,
    input  logic                   rst,
    input  logic                   start,
    input  nfcCmdPkg::cmdRequest_t request,
    output logic                   ready,
    output logic                   lastStep,
    output nfcCmdPkg::padBus_t     pads
);

    import nfcCmdPkg::*;

    cmdState_t   state;
    logic        timerClear;
    logic        phaseDone;
    logic        strobeLow;
    logic        load;
    logic        advance;
    logic        lastByte;
    cmdRequest_t held;
    caByte_t     currentByte;

    nfcCmdSequencer u_sequencer (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .start        (start),
        .phaseDone    (phaseDone),
        .lastByte     (lastByte),
        .state        (state),
        .timerClear   (timerClear),
        .load         (load),
        .advance      (advance),
        .ready        (ready),
        .lastStep     (lastStep)
    );

    nfcPhaseTimer u_timer (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .timerClear   (timerClear),
        .phaseDone    (phaseDone),
        .strobeLow    (strobeLow)
    );

    nfcCaShifter u_shifter (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .load         (load),
        .advance      (advance),
        .request      (request),
        .held         (held),
        .currentByte  (currentByte),
        .lastByte     (lastByte)
    );

    nfcPadDriver u_padDriver (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .state        (state),
        .held         (held),
        .currentByte  (currentByte),
        .strobeLow    (strobeLow),
        .pads         (pads)
    );

endmodule

//--- source/nfcPadDriver.sv
`timescale 1ns/1ps

module nfcPadDriver (
    input  logic                   iSystemClock,
    input  logic                   rst,
    input  nfcCmdPkg::cmdState_t   state,
    input  nfcCmdPkg::cmdRequest_t held,
    input  nfcCmdPkg::caByte_t     currentByte,
    input  logic                   strobeLow,
    output nfcCmdPkg::padBus_t     pads
);

    import nfcCmdPkg::*;

    logic    byteOut;
    dqWord_t dqNext;

    assign byteOut = (state == Output);

    // same byte on every lane of the bus
    assign dqNext = byteOut ? {($bits(dqWord_t) / $bits(caByte_t)){currentByte}} : '0;

    // pads follow the state one cycle later
    always_ff @(posedge iSystemClock) begin
        if (rst || state == Ready) begin
            pads.chipEnable         <= '1;
            pads.writeEnable        <= WeIdle;
            pads.addressLatchEnable <= LaneIdle;
            pads.commandLatchEnable <= LaneIdle;
            pads.dq                 <= '0;
        end else begin
            pads.chipEnable <= {~held.targetWay, ~held.targetWay}; // both pad halves
            pads.writeEnable <= (byteOut && strobeLow) ? WeActive : WeIdle;
            if (held.caSelect) begin
                pads.addressLatchEnable <= LaneIdle;
                pads.commandLatchEnable <= LaneActive;
            end else begin
                pads.addressLatchEnable <= LaneActive;
                pads.commandLatchEnable <= LaneIdle;
            end
            pads.dq <= dqNext;
        end
    end

endmodule

//--- source/nfcPhaseTimer.sv
`timescale 1ns/1ps

module nfcPhaseTimer (
    input  logic iSystemClock,
    input  logic rst,
    input  logic timerClear,
    output logic phaseDone,
    output logic strobeLow
);

    import nfcCmdPkg::*;

    timerCount_t count;

    // free running, restarted by the sequencer at command start
    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            count <= '0;
        end else if (timerClear) begin
            count <= '0;
        end else if (count == TimerLast) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign phaseDone = (count == TimerLast);
    assign strobeLow = (count <= StrobeLowLast); // first half of a byte phase

endmodule

//--- src.f
source/nfcCmdPkg.sv
source/nfcPhaseTimer.sv
source/nfcCmdSequencer.sv
source/nfcCaShifter.sv
source/nfcPadDriver.sv
source/nfcCmdTop.sv
tb/nfcCmdTb_sva.sv
tb/nfcCmdTb.sv

//--- tb/nfcCmdTb.sv
`timescale 1ns/1ps

module nfcCmdTb;

    import nfcCmdPkg::*;

    localparam int PhaseCycles   = 10; // one setup or byte phase
    localparam int SetupCycles   = 10;
    localparam int WeLowCycles   = 5;
    localparam int ReadyTimeout  = 200;
    localparam int NumCommands   = 40;
    localparam logic [15:0] Seed = 16'd60587;

    logic        iSystemClock = 1'b0;
    logic        rst;
    logic        start;
    cmdRequest_t request;
    logic        ready;
    logic        lastStep;
    padBus_t     pads;

    // reference model state
    logic        modelActive;
    logic        modelReady;
    int          modelCycle; // 0 is the latch cycle
    int          modelBytes;
    cmdRequest_t modelReq;

    logic [15:0] lfsrState;
    int          pulseCount;
    laneCtl_t    prevWe;
    int          commandsDone;

    nfcCmdTop u_dut (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .start        (start),
        .request      (request),
        .ready        (ready),
        .lastStep     (lastStep),
        .pads         (pads)
    );

    always #20 iSystemClock = ~iSystemClock;

    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1
        end
        return next;
    endfunction

    task automatic drawBits(input int count, output logic [39:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value     = {value[38:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    function automatic int byteTotal(input byteCount_t numOfData);
        return (int'(numOfData) > 4) ? 5 : int'(numOfData) + 1;
    endfunction

    function automatic int lastCycleOf(input int bytes);
        return SetupCycles + PhaseCycles * bytes;
    endfunction

    function automatic caByte_t byteOf(input caData_t data, input int index);
        return caByte_t'(data >> (8 * (4 - index))); // top byte is index 0
    endfunction

    function automatic padBus_t predictPads(input logic active, input int cycle,
                                            input cmdRequest_t req);
        padBus_t p;
        int      offset;
        p.chipEnable         = '1;
        p.writeEnable        = WeIdle;
        p.addressLatchEnable = LaneIdle;
        p.commandLatchEnable = LaneIdle;
        p.dq                 = '0;
        if (active && cycle > 0) begin
            p.chipEnable = {~req.targetWay, ~req.targetWay};
            if (req.caSelect) begin
                p.commandLatchEnable = LaneActive;
            end else begin
                p.addressLatchEnable = LaneActive;
            end
            if (cycle > SetupCycles) begin
                offset = cycle - SetupCycles - 1;
                p.dq   = {4{byteOf(req.caData, offset / PhaseCycles)}};
                if ((offset % PhaseCycles) < WeLowCycles) begin
                    p.writeEnable = WeActive;
                end
            end
        end
        return p;
    endfunction

    task automatic abortRun();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkPads(input padBus_t expected, input padBus_t actual, input string name);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkByte(input caByte_t expected, input caByte_t actual, input string name);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkBit(input logic expected, input logic actual, input string name);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %b actual %b", $time, name, expected, actual);
            abortRun();
        end
    endtask

    // cycle model of the handshake, updated with the DUT's own edge
    always @(posedge iSystemClock) begin
        if (rst) begin
            modelActive <= 1'b0;
            modelReady  <= 1'b0;
        end else if (!modelActive) begin
            if (modelReady && start) begin
                modelActive <= 1'b1;
                modelCycle  <= 0;
                modelReq    <= request;
                modelBytes  <= byteTotal(request.numOfData);
                modelReady  <= 1'b0;
            end else begin
                modelReady <= 1'b1;
            end
        end else if (modelCycle == lastCycleOf(modelBytes)) begin
            modelActive <= 1'b0;
            modelReady  <= 1'b1;
        end else begin
            modelCycle <= modelCycle + 1;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge iSystemClock) begin
        padBus_t expectedPads;
        logic    expectedLast;
        int      offset;
        int      lane;
        expectedPads = predictPads(modelActive, modelCycle, modelReq);
        expectedLast = modelActive && (modelCycle == lastCycleOf(modelBytes));
        checkPads(expectedPads, pads, "pads");
        checkBit(modelReady, ready, "ready");
        checkBit(expectedLast, lastStep, "lastStep");
        if (modelActive && modelCycle > SetupCycles) begin
            offset = modelCycle - SetupCycles - 1;
            if ((offset % PhaseCycles) == WeLowCycles - 1) begin // end of the low pulse
                for (lane = 0; lane < 4; lane++) begin
                    checkByte(byteOf(modelReq.caData, offset / PhaseCycles),
                              pads.dq[8*lane +: 8], "pads.dq lane byte");
                end
            end
        end
        if (modelActive && modelCycle == 0) begin
            pulseCount = 0;
        end
        if (pads.writeEnable == WeActive && prevWe != WeActive) begin
            pulseCount++;
        end
        prevWe = pads.writeEnable;
        if (expectedLast) begin
            checkByte(caByte_t'(modelBytes), caByte_t'(pulseCount), "write enable pulses");
            commandsDone++;
        end
    end

    task automatic waitForReady(input string what);
        int waited;
        waited = 0;
        @(negedge iSystemClock);
        while (ready !== 1'b1) begin
            if (waited == ReadyTimeout) begin
                $display("timeout: ready stayed low while %s", what);
                abortRun();
            end
            waited++;
            @(negedge iSystemClock);
        end
    endtask

    task automatic issueCommand(input cmdRequest_t req);
        @(posedge iSystemClock);
        start   <= 1'b1;
        request <= req;
        waitForReady("a start was pending");
        // taken at this edge
        @(posedge iSystemClock);
        start   <= 1'b0;
        request <= cmdRequest_t'(~req); // must not reach the pads
    endtask

    task automatic makeRequest(output cmdRequest_t req);
        logic [39:0] bits;
        drawBits(4, bits);
        req.targetWay = (bits[3:0] == 4'b0000) ? 4'b1000 : bits[3:0];
        drawBits(4, bits);
        req.numOfData = bits[3:0];
        drawBits(1, bits);
        req.caSelect = bits[0];
        drawBits(40, bits);
        req.caData = bits;
    endtask

    initial begin
        cmdRequest_t req;
        logic [39:0] bits;
        int          n;
        int          gap;
        int          i;
        rst          = 1'b1;
        start        = 1'b0;
        request      = '0;
        lfsrState    = Seed;
        pulseCount   = 0;
        prevWe       = WeIdle;
        commandsDone = 0;
        repeat (2) @(posedge iSystemClock);
        rst <= 1'b0;
        waitForReady("leaving reset");
        for (n = 0; n < NumCommands; n++) begin
            makeRequest(req);
            issueCommand(req);
            // short gap, the DUT is still busy so stray starts are ignored
            drawBits(3, bits);
            gap = int'(bits[2:0]);
            for (i = 0; i < gap; i++) begin
                drawBits(1, bits);
                @(posedge iSystemClock);
                start <= bits[0];
            end
            @(posedge iSystemClock);
            start <= 1'b0;
            drawBits(1, bits);
            if (bits[0]) begin
                waitForReady("finishing a command");
                drawBits(2, bits);
                repeat (int'(bits[1:0])) @(posedge iSystemClock);
            end
        end
        waitForReady("finishing the last command");
        repeat (2) @(negedge iSystemClock);
        if (commandsDone != NumCommands) begin
            $display("only %0d of %0d commands reached their last step",
                     commandsDone, NumCommands);
            $display("Simulation FAILED");
            $fatal(1, "command count mismatch");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- tb/nfcCmdTb_sva.sv
`timescale 1ns/1ps

module nfcCmdSva (
    input logic               iSystemClock,
    input logic               rst,
    input logic               ready,
    input logic               lastStep,
    input nfcCmdPkg::padBus_t pads
);

    import nfcCmdPkg::*;

    // one latch lane set at a time
    latchExclusive: assert property (@(posedge iSystemClock) disable iff (rst)
        !((pads.addressLatchEnable != LaneIdle) && (pads.commandLatchEnable != LaneIdle)))
        else $error("address and command latch enables active together");

    weWithChip: assert property (@(posedge iSystemClock) disable iff (rst)
        (pads.writeEnable == WeActive) |-> (pads.chipEnable != '1))
        else $error("write enable pulsed with no chip enable active");

    // handshake closes one cycle after the last step
    readyAfterLast: assert property (@(posedge iSystemClock) disable iff (rst)
        lastStep |=> ready)
        else $error("ready did not follow lastStep");

endmodule

bind nfcCmdTop nfcCmdSva u_sva (.*);
